/* logic/uart_echo_pkg.sv */
//--------------------
// uart echo package
// shared widths, register map, reset defaults and bundles
//--------------------
package uart_echo_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] baud_div_t;   // clocks per bit minus one
	typedef logic [23:0] idle_cnt_t;
	typedef logic [5:0]  buf_idx_t;
	typedef logic [7:0]  drop_cnt_t;
	typedef logic [1:0]  reg_addr_t;
	typedef logic [31:0] reg_data_t;

	localparam int unsigned BUF_DEPTH   = 64;
	localparam buf_idx_t    MAX_PAYLOAD = 6'd62;   // two slots kept for the terminators

	localparam reg_addr_t ADDR_BAUD = 2'd0;
	localparam reg_addr_t ADDR_IDLE = 2'd1;
	localparam reg_addr_t ADDR_TERM = 2'd2;   // term1 in 15:8, term0 in 7:0
	localparam reg_addr_t ADDR_DROP = 2'd3;   // read only, write clears

	localparam baud_div_t DEF_BAUD_DIV = 16'd433;   // 115200 at 50 MHz
	localparam idle_cnt_t DEF_IDLE     = 24'd50000;
	localparam byte_t     DEF_TERM0    = 8'h0D;
	localparam byte_t     DEF_TERM1    = 8'h0A;

	typedef struct packed {
		logic      wr;
		logic      rd;
		reg_addr_t addr;
		reg_data_t wdata;
	} reg_req_t;

	typedef struct packed {
		baud_div_t baud_div;
		idle_cnt_t idle_cycles;
		byte_t     term0;
		byte_t     term1;
	} echo_cfg_t;

	typedef struct packed {
		logic drop;   // one cycle per discarded byte
	} echo_stat_t;

	typedef enum logic [1:0] {
		ECHO_IDLE,
		ECHO_GATHER,
		ECHO_SEND,
		ECHO_TERM
	} echo_state_t;

endpackage

/* logic/uart_rx.sv */
//--------------------
// uart receiver
// 8N1, mid-bit sampling, start glitch reject and stop check
//--------------------
`timescale 1ns/1ps

module uart_rx (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  logic                     rx,
	input  uart_echo_pkg::echo_cfg_t cfg,
	output uart_echo_pkg::byte_t     rx_byte,
	output logic                     rx_vld,
	output logic                     rx_ferr
);

	logic                     rx_meta;
	logic                     rx_sync;
	logic                     rx_prev;   // for falling edge detect
	logic                     busy;
	logic [3:0]               bit_idx;   // 0 start, 1..8 data, 9 stop
	uart_echo_pkg::baud_div_t clk_cnt;
	uart_echo_pkg::baud_div_t target;
	logic                     sample;

	// half a bit for the start check, full bits afterwards
	assign target = (bit_idx == 4'd0) ? {1'b0, cfg.baud_div[15:1]} : cfg.baud_div;
	assign sample = busy && (clk_cnt == target);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			bit_idx <= 4'd0;
			clk_cnt <= '0;
			rx_vld  <= 1'b0;
			rx_ferr <= 1'b0;
		end else begin
			rx_vld  <= 1'b0;
			rx_ferr <= 1'b0;
			if (!busy) begin
				if (rx_prev && !rx_sync) begin   // start edge
					busy    <= 1'b1;
					bit_idx <= 4'd0;
					clk_cnt <= '0;
				end
			end else if (sample) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd0) begin
					if (rx_sync)
						busy <= 1'b0;   // line back high, glitch
					else
						bit_idx <= 4'd1;
				end else if (bit_idx == 4'd9) begin
					busy    <= 1'b0;
					rx_vld  <= rx_sync;
					rx_ferr <= !rx_sync;   // stop bit low
				end else begin
					bit_idx <= bit_idx + 4'd1;
				end
			end else begin
				clk_cnt <= clk_cnt + 16'd1;
			end
		end
	end

	// data shifts in LSB first, holds through the stop bit
	always_ff @(posedge sys_clk) begin
		if (sample && (bit_idx != 4'd0) && (bit_idx != 4'd9))
			rx_byte <= {rx_sync, rx_byte[7:1]};
	end

endmodule

/* logic/uart_tx.sv */
//--------------------
// uart transmitter
// 8N1 frame per tx_start, done on last stop-bit cycle
//--------------------
`timescale 1ns/1ps

module uart_tx (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  uart_echo_pkg::echo_cfg_t cfg,
	input  uart_echo_pkg::byte_t     tx_byte,
	input  logic                     tx_start,
	output logic                     tx,
	output logic                     tx_done
);

	logic                     busy;
	logic [3:0]               bit_idx;   // 0 start, 1..8 data, 9 stop
	uart_echo_pkg::baud_div_t clk_cnt;
	logic [8:0]               shift;     // stop bit on top of the data
	logic                     load;
	logic                     bit_end;

	assign load    = tx_start && !busy;
	assign bit_end = busy && (clk_cnt == cfg.baud_div);
	assign tx_done = bit_end && (bit_idx == 4'd9);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			bit_idx <= 4'd0;
			clk_cnt <= '0;
			tx      <= 1'b1;
		end else if (load) begin
			busy    <= 1'b1;
			bit_idx <= 4'd0;
			clk_cnt <= '0;
			tx      <= 1'b0;   // start bit
		end else if (busy) begin
			if (bit_end) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd9) begin
					busy <= 1'b0;   // line stays high
				end else begin
					bit_idx <= bit_idx + 4'd1;
					tx      <= shift[0];
				end
			end else begin
				clk_cnt <= clk_cnt + 16'd1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load)
			shift <= {1'b1, tx_byte};
		else if (bit_end)
			shift <= {1'b1, shift[8:1]};   // ones fill behind the stop bit
	end

endmodule

/* logic/echo_regs.sv */
//--------------------
// echo register block
// config registers, drop counter, registered read
//--------------------
`timescale 1ns/1ps

module echo_regs (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  uart_echo_pkg::reg_req_t   req,
	input  uart_echo_pkg::echo_stat_t stat,
	output uart_echo_pkg::echo_cfg_t  cfg,
	output uart_echo_pkg::reg_data_t  rdata
);

	uart_echo_pkg::drop_cnt_t drop_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cfg.baud_div    <= uart_echo_pkg::DEF_BAUD_DIV;
			cfg.idle_cycles <= uart_echo_pkg::DEF_IDLE;
			cfg.term0       <= uart_echo_pkg::DEF_TERM0;
			cfg.term1       <= uart_echo_pkg::DEF_TERM1;
		end else if (req.wr) begin
			case (req.addr)
				uart_echo_pkg::ADDR_BAUD: cfg.baud_div <= req.wdata[15:0];
				uart_echo_pkg::ADDR_IDLE: cfg.idle_cycles <= req.wdata[23:0];
				uart_echo_pkg::ADDR_TERM: begin
					cfg.term0 <= req.wdata[7:0];
					cfg.term1 <= req.wdata[15:8];
				end
				default: ;   // drop count handled below
			endcase
		end
	end

	// saturating, a write clears it even on a drop cycle
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			drop_cnt <= '0;
		else if (req.wr && (req.addr == uart_echo_pkg::ADDR_DROP))
			drop_cnt <= '0;
		else if (stat.drop && (drop_cnt != '1))
			drop_cnt <= drop_cnt + 8'd1;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rdata <= '0;
		end else if (req.rd) begin
			case (req.addr)
				uart_echo_pkg::ADDR_BAUD: rdata <= {16'd0, cfg.baud_div};
				uart_echo_pkg::ADDR_IDLE: rdata <= {8'd0, cfg.idle_cycles};
				uart_echo_pkg::ADDR_TERM: rdata <= {16'd0, cfg.term1, cfg.term0};
				default:                  rdata <= {24'd0, drop_cnt};
			endcase
		end
	end

endmodule

/* logic/echo_ctrl.sv */
//--------------------
// echo controller
// line buffer, idle timer, echo FSM with terminator pair
//--------------------
`timescale 1ns/1ps

module echo_ctrl (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  uart_echo_pkg::echo_cfg_t  cfg,
	input  uart_echo_pkg::byte_t      rx_byte,
	input  logic                      rx_vld,
	input  logic                      rx_ferr,
	input  logic                      tx_done,
	output uart_echo_pkg::byte_t      tx_byte,
	output logic                      tx_start,
	output uart_echo_pkg::echo_stat_t stat
);

	uart_echo_pkg::byte_t       line_buf [uart_echo_pkg::BUF_DEPTH];
	uart_echo_pkg::echo_state_t state;
	uart_echo_pkg::buf_idx_t    wr_cnt;       // bytes held
	uart_echo_pkg::buf_idx_t    rd_idx;
	uart_echo_pkg::idle_cnt_t   idle_tmr;
	logic                       send_first;   // kicks the first frame
	logic                       term_sel;     // term1 still to go
	logic                       gathering;
	logic                       accept;
	logic                       idle_hit;
	logic                       issue;
	uart_echo_pkg::byte_t       next_byte;

	assign gathering = (state == uart_echo_pkg::ECHO_IDLE) ||
			(state == uart_echo_pkg::ECHO_GATHER);
	assign accept    = rx_vld && gathering && (wr_cnt != uart_echo_pkg::MAX_PAYLOAD);
	assign idle_hit  = ({1'b0, idle_tmr} + 25'd1) >= {1'b0, cfg.idle_cycles};

	// pick the next frame, launched on the cycle after tx_done
	always_comb begin
		issue     = 1'b0;
		next_byte = line_buf[rd_idx];
		case (state)
			uart_echo_pkg::ECHO_SEND: begin
				if (send_first || tx_done) begin
					issue = 1'b1;
					if (rd_idx == wr_cnt)
						next_byte = cfg.term0;   // payload done
				end
			end
			uart_echo_pkg::ECHO_TERM: begin
				if (tx_done && term_sel) begin
					issue     = 1'b1;
					next_byte = cfg.term1;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			line_buf[wr_cnt] <= rx_byte;
	end

	always_ff @(posedge sys_clk) begin
		if (issue)
			tx_byte <= next_byte;
	end

	// bad stop bit, busy echo or full line
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			stat.drop <= 1'b0;
		else
			stat.drop <= rx_ferr || (rx_vld && !accept);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= uart_echo_pkg::ECHO_IDLE;
			wr_cnt     <= '0;
			rd_idx     <= '0;
			idle_tmr   <= '0;
			send_first <= 1'b0;
			term_sel   <= 1'b0;
			tx_start   <= 1'b0;
		end else begin
			tx_start <= issue;
			case (state)
				uart_echo_pkg::ECHO_IDLE: begin
					if (accept) begin
						state    <= uart_echo_pkg::ECHO_GATHER;
						wr_cnt   <= wr_cnt + 6'd1;
						idle_tmr <= '0;
					end
				end
				uart_echo_pkg::ECHO_GATHER: begin
					if (accept) begin
						wr_cnt   <= wr_cnt + 6'd1;
						idle_tmr <= '0;   // restart on every byte taken
					end else if (idle_hit) begin
						idle_tmr <= '0;
						rd_idx   <= '0;
						if (wr_cnt == '0) begin
							state <= uart_echo_pkg::ECHO_IDLE;   // nothing to echo
						end else begin
							state      <= uart_echo_pkg::ECHO_SEND;
							send_first <= 1'b1;
						end
					end else begin
						idle_tmr <= idle_tmr + 24'd1;
					end
				end
				uart_echo_pkg::ECHO_SEND: begin
					if (issue) begin
						send_first <= 1'b0;
						if (rd_idx == wr_cnt) begin
							state    <= uart_echo_pkg::ECHO_TERM;   // term0 going out
							term_sel <= 1'b1;
						end else begin
							rd_idx <= rd_idx + 6'd1;
						end
					end
				end
				default: begin
					if (tx_done) begin
						if (term_sel) begin
							term_sel <= 1'b0;
						end else begin
							state  <= uart_echo_pkg::ECHO_IDLE;   // term1 finished
							wr_cnt <= '0;
						end
					end
				end
			endcase
		end
	end

endmodule

/* logic/uart_echo_top.sv */
//--------------------
// uart echo top
// registers, echo controller and both uart engines
//--------------------
`timescale 1ns/1ps

module uart_echo_top (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  uart_echo_pkg::reg_req_t  reg_req,
	input  logic                     uart_rxd,
	output uart_echo_pkg::reg_data_t reg_rdata,
	output logic                     uart_txd
);

	uart_echo_pkg::echo_cfg_t  cfg;
	uart_echo_pkg::echo_stat_t stat;
	uart_echo_pkg::byte_t      rx_byte;
	logic                      rx_vld;
	logic                      rx_ferr;
	uart_echo_pkg::byte_t      tx_byte;
	logic                      tx_start;
	logic                      tx_done;

	echo_regs u_regs (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.req       (reg_req),
		.stat      (stat),
		.cfg       (cfg),
		.rdata     (reg_rdata)
	);

	echo_ctrl u_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cfg       (cfg),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.rx_ferr   (rx_ferr),
		.tx_done   (tx_done),
		.tx_byte   (tx_byte),
		.tx_start  (tx_start),
		.stat      (stat)
	);

	uart_rx u_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rxd),
		.cfg       (cfg),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld),
		.rx_ferr   (rx_ferr)
	);

	uart_tx u_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cfg       (cfg),
		.tx_byte   (tx_byte),
		.tx_start  (tx_start),
		.tx        (uart_txd),
		.tx_done   (tx_done)
	);

endmodule

/* dv/uart_echo_chk.sv */
//--------------------
// echo checker
// transmit strobe and serial idle level
//--------------------
`timescale 1ns/1ps

module uart_echo_chk (
	input logic                       sys_clk,
	input logic                       sys_rst_n,
	input uart_echo_pkg::echo_state_t state,
	input logic                       tx_start,
	input logic                       tx_done,
	input logic                       txd
);

	logic        in_frame;       // between tx_start and tx_done
	int unsigned fail_cnt = 0;   // assertion failures so far

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			in_frame <= 1'b0;
		else if (tx_start)
			in_frame <= 1'b1;
		else if (tx_done)
			in_frame <= 1'b0;
	end

	start_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_start |=> !tx_start)
		else begin
			$error("tx_start high on two cycles in a row");
			fail_cnt++;
		end

	start_free: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_start |-> !in_frame)
		else begin
			$error("tx_start while a frame is still going out");
			fail_cnt++;
		end

	// nothing may leave the transmitter before the echo starts
	line_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		((state == uart_echo_pkg::ECHO_IDLE) || (state == uart_echo_pkg::ECHO_GATHER)) |-> txd)
		else begin
			$error("uart_txd low outside of an echo");
			fail_cnt++;
		end

endmodule

/* dv/uart_echo_tb.sv */
//--------------------
// uart echo testbench
// vector-driven register traffic, serial driver, echo decoder
//--------------------
`timescale 1ns/1ps

module uart_echo_tb;

	logic                     sys_clk;
	logic                     sys_rst_n;
	uart_echo_pkg::reg_req_t  reg_req;
	logic                     uart_rxd;
	uart_echo_pkg::reg_data_t reg_rdata;
	logic                     uart_txd;

	int unsigned          bit_clks;    // follows the baud register writes
	int unsigned          idle_clks;
	int unsigned          err_cnt   = 0;
	int unsigned          cyc       = 0;
	int unsigned          cyc_limit = 2000;
	logic                 sending;     // decoder quiet count waits for this
	uart_echo_pkg::byte_t send_q[$];
	uart_echo_pkg::byte_t exp_q[$];
	uart_echo_pkg::byte_t got_q[$];

	uart_echo_top DUT (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.reg_req   (reg_req),
		.uart_rxd  (uart_rxd),
		.reg_rdata (reg_rdata),
		.uart_txd  (uart_txd)
	);

	bind echo_ctrl uart_echo_chk u_chk (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.state     (state),
		.tx_start  (tx_start),
		.tx_done   (tx_done),
		.txd       (uart_echo_tb.DUT.uart_txd)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cyc <= cyc + 1;
		if (cyc > cyc_limit) begin
			$display("timeout, echo not finished after %0d cycles", cyc);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// one-cycle strobe, read data checked on the next cycle
	task automatic reg_access(input logic wr, input logic [31:0] addr, input logic [31:0] data);
		uart_echo_pkg::reg_req_t req;
		req       = '0;
		req.wr    = wr;
		req.rd    = !wr;
		req.addr  = addr[1:0];
		req.wdata = wr ? data : '0;
		@(posedge sys_clk);
		reg_req <= req;
		@(posedge sys_clk);
		reg_req <= '0;
		@(negedge sys_clk);
		if (!wr)
			compare($sformatf("reg_rdata[%0d]", addr), reg_rdata, data);
	endtask

	task automatic send_byte(input uart_echo_pkg::byte_t b, input logic bad);
		logic [9:0] frame;
		int         i;
		frame = {!bad, b, 1'b0};   // stop, data, start
		@(posedge sys_clk);
		for (i = 0; i < 10; i++) begin
			uart_rxd <= frame[i];
			repeat (bit_clks) @(posedge sys_clk);
		end
		uart_rxd <= 1'b1;
	endtask

	// collects frames until the line has been quiet long enough
	task automatic decode_echo();
		int unsigned          quiet;
		int                   i;
		uart_echo_pkg::byte_t b;
		quiet = 0;
		while (quiet < idle_clks + 40 * bit_clks) begin
			@(negedge sys_clk);
			if (uart_txd === 1'b0) begin
				quiet = 0;
				repeat (bit_clks / 2) @(negedge sys_clk);   // mid start bit
				for (i = 0; i < 8; i++) begin
					repeat (bit_clks) @(negedge sys_clk);
					b[i] = uart_txd;
				end
				repeat (bit_clks) @(negedge sys_clk);
				compare("uart_txd stop bit", uart_txd, 1'b1);
				got_q.push_back(b);
			end else if (!sending) begin
				quiet++;
			end
		end
	endtask

	task automatic push_text(input logic [8*80-1:0] t, input logic to_exp);
		int i;
		for (i = 79; i >= 0; i--) begin
			if (t[i*8 +: 8] != 8'h00) begin
				if (to_exp)
					exp_q.push_back(t[i*8 +: 8]);
				else
					send_q.push_back(t[i*8 +: 8]);
			end
		end
	endtask

	task automatic run_line(input uart_echo_pkg::byte_t t0, input uart_echo_pkg::byte_t t1,
			input logic late_en, input uart_echo_pkg::byte_t late_b, input int bad_idx);
		int i;
		// three times the frames of this echo, plus its idle wait and quiet tail
		cyc_limit = cyc_limit + 3 * (10 * bit_clks * (send_q.size() + exp_q.size() + 2 + late_en)
				+ 2 * idle_clks + 40 * bit_clks);
		sending = 1'b1;
		fork
			begin
				for (i = 0; i < send_q.size(); i++) begin
					send_byte(send_q[i], i == bad_idx);
					repeat (bit_clks + $urandom % (idle_clks / 4)) @(posedge sys_clk);
				end
				sending = 1'b0;
				if (late_en) begin
					@(negedge uart_txd);   // echo under way
					send_byte(late_b, 1'b0);
				end
			end
			decode_echo();
		join
		exp_q.push_back(t0);
		exp_q.push_back(t1);
		compare("echo length", got_q.size(), exp_q.size());
		for (i = 0; (i < exp_q.size()) && (i < got_q.size()); i++)
			compare($sformatf("uart_txd byte %0d", i), got_q[i], exp_q[i]);
		send_q.delete();
		exp_q.delete();
		got_q.delete();
	endtask

	initial begin
		int                   fd;
		logic [7:0]           kind;
		string                line;
		logic [8*80-1:0]      tok;
		logic [31:0]          a;
		logic [31:0]          d;
		int                   bad_idx;
		logic                 late_en;
		uart_echo_pkg::byte_t late_b;
		void'($urandom(68));
		reg_req   = '0;
		uart_rxd  = 1'b1;
		sys_rst_n = 1'b0;
		sending   = 1'b0;
		bit_clks  = uart_echo_pkg::DEF_BAUD_DIV + 1;
		idle_clks = uart_echo_pkg::DEF_IDLE;
		bad_idx   = -1;
		late_en   = 1'b0;
		late_b    = '0;
		repeat (3) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		fd = $fopen("dv/uart_echo_vectors.txt", "r");
		if (fd == 0) begin
			err_cnt++;
			$display("cannot open dv/uart_echo_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				kind = "#";
				tok  = '0;
				void'($fgets(line, fd));
				void'($sscanf(line, "%s", kind));
				case (kind)
					"#": ;   // comment or blank line
					"W", "R": begin
						void'($sscanf(line, "%s %h %h", kind, a, d));
						reg_access(kind == "W", a, d);
						if ((kind == "W") && (a == 0))
							bit_clks = d[15:0] + 1;
						if ((kind == "W") && (a == 1))
							idle_clks = d[23:0];
					end
					"S", "E": begin
						void'($sscanf(line, "%s %s", kind, tok));
						push_text(tok, kind == "E");
					end
					"B": void'($sscanf(line, "%s %d", kind, bad_idx));
					"L": begin
						void'($sscanf(line, "%s %h", kind, late_b));
						late_en = 1'b1;
					end
					"C": begin
						void'($sscanf(line, "%s %h %h", kind, a, d));
						run_line(a[7:0], d[7:0], late_en, late_b, bad_idx);
						bad_idx = -1;
						late_en = 1'b0;
					end
					default: begin
						err_cnt++;
						$display("vector line not understood: %s", line);
					end
				endcase
			end
			$fclose(fd);
		end
		$display("checks done: %0d errors, %0d assertion failures", err_cnt,
				DUT.u_ctrl.u_chk.fail_cnt);
		if ((err_cnt == 0) && (DUT.u_ctrl.u_chk.fail_cnt == 0)) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* dv/uart_echo_vectors.txt */
# W/R addr hex: register write, or read checked against hex | S/E text: sent, expected echo
# B idx: bad stop bit on byte idx | L hh: byte sent during the echo | C t0 t1: run line
R 0 1b1
R 2 0a0d
W 0 7
W 1 190
R 0 7
R 1 190
S hello
E hello
C 0d 0a
W 2 2a23
S term
E term
C 23 2a
W 2 0a0d
S abXcd
E abcd
B 2
C 0d 0a
R 3 1
W 3 0
S 0123456789abcdefghijklmnopqrstuvwxyzABCDEFGHIJKLMNOPQRSTUVWXYZ!?*
E 0123456789abcdefghijklmnopqrstuvwxyzABCDEFGHIJKLMNOPQRSTUVWXYZ
C 0d 0a
R 3 3
W 3 0
R 3 0
S busy
E busy
L 5a
C 0d 0a
R 3 1

/* files.f */
logic/uart_echo_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/echo_regs.sv
logic/echo_ctrl.sv
logic/uart_echo_top.sv
dv/uart_echo_chk.sv
dv/uart_echo_tb.sv

/* Bender.yml */
package:
  name: uart_echo

sources:
  - files:
      - logic/uart_echo_pkg.sv
      - logic/uart_rx.sv
      - logic/uart_tx.sv
      - logic/echo_regs.sv
      - logic/echo_ctrl.sv
      - logic/uart_echo_top.sv
  - target: simulation
    files:
      - dv/uart_echo_chk.sv
      - dv/uart_echo_tb.sv
